/* verilog/rx_link_pkg.sv */
// control characters, frame state type and packed structs for the
// TLK2711 receive link
`default_nettype none

package rx_link_pkg;

    localparam int ADDR_W = 32;
    localparam int DDR_W  = 64;

    // one character from the transceiver, K flags above the data
    typedef struct packed {
        logic        rkmsb;
        logic        rklsb;
        logic [15:0] data;
    } rx_char_t;

    localparam rx_char_t CHAR_SYNC      = '{rkmsb: 1'b0, rklsb: 1'b1, data: 16'hC5BC};
    localparam rx_char_t CHAR_SOF       = '{rkmsb: 1'b1, rklsb: 1'b1, data: 16'h5CFB};
    localparam rx_char_t CHAR_LINK_DOWN = '{rkmsb: 1'b1, rklsb: 1'b1, data: 16'hFFFF};

    // two head words, first word in the upper half
    localparam logic [31:0] FRAME_HEAD_FLAG = 32'hEB90_E116;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SYNC,
        ST_HEAD,
        ST_TYPE,
        ST_LINE,
        ST_LENGTH,
        ST_DATA,
        ST_CHECK,
        ST_END1,
        ST_END2
    } rx_state_t;

    // type word carries file_end..data_type plus line_number[23:16]
    typedef struct packed {
        logic [1:0]  file_end;
        logic [1:0]  channel_id;
        logic [3:0]  data_type;
        logic [23:0] line_number;
        logic [15:0] data_length;
    } rx_header_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [15:0]       byte_count;
    } dma_cmd_t;

endpackage

`default_nettype wire

/* verilog/rx_frame_parser.sv */
// frame FSM for the receive link, header capture and checksum compare
`timescale 1ns/1ps
`default_nettype none

module rx_frame_parser
    import rx_link_pkg::*;
(
    input  wire        i_2711_rx_clk,
    input  wire        i_rst_n,
    input  wire        rx_char_t i_char,
    output logic       o_word_valid,
    output logic [15:0] o_word,
    output logic       o_hdr_valid,
    output rx_header_t o_header,
    output logic       o_frame_done,
    output logic       o_checksum_error,
    output logic       o_in_frame
);

    rx_state_t   cs;
    rx_state_t   ns;
    logic [15:0] prev_data;
    logic [15:0] checksum;
    logic [15:0] data_cnt;
    logic [15:0] num_words;

    // payload word count where an odd byte length takes one extra word
    assign num_words = {1'b0, o_header.data_length[15:1]} + 16'(o_header.data_length[0]);

    assign o_in_frame = (cs == ST_TYPE) || (cs == ST_LINE) || (cs == ST_LENGTH) ||
                        (cs == ST_DATA) || (cs == ST_CHECK);

    assign o_word = prev_data;

    ////////////////////////////////////////////////////////////////////////////
    // frame state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ns = cs;
        case (cs)
            ST_IDLE: begin
                if (i_char == CHAR_SYNC) ns = ST_SYNC;
            end
            ST_SYNC: begin
                if (i_char == CHAR_SOF) ns = ST_HEAD;
            end
            ST_HEAD: begin
                // previous word together with the current one
                if ({prev_data, i_char.data} == FRAME_HEAD_FLAG) ns = ST_TYPE;
            end
            ST_TYPE:   ns = ST_LINE;
            ST_LINE:   ns = ST_LENGTH;
            ST_LENGTH: ns = ST_DATA;
            ST_DATA: begin
                if (data_cnt == num_words - 16'd1) ns = ST_CHECK;
            end
            ST_CHECK:  ns = ST_END1;
            ST_END1:   ns = ST_END2;
            ST_END2:   ns = ST_IDLE;
            default:   ns = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cs               <= ST_IDLE;
            data_cnt         <= '0;
            checksum         <= '0;
            o_checksum_error <= 1'b0;
            o_word_valid     <= 1'b0;
            o_hdr_valid      <= 1'b0;
            o_frame_done     <= 1'b0;
        end else begin
            cs           <= ns;
            o_word_valid <= (cs == ST_DATA);
            o_hdr_valid  <= (cs == ST_LENGTH);
            o_frame_done <= (cs == ST_END1);
            data_cnt     <= (cs == ST_DATA) ? data_cnt + 16'd1 : 16'd0;

            // wrapping sum over type, line, length and payload
            case (cs)
                ST_IDLE:  checksum <= '0;
                ST_TYPE, ST_LINE, ST_LENGTH, ST_DATA: begin
                    checksum <= checksum + i_char.data;
                end
                ST_CHECK: o_checksum_error <= (checksum != i_char.data);
                default: ;
            endcase
        end
    end

    // header fields and the delayed data word
    always_ff @(posedge i_2711_rx_clk) begin
        prev_data <= i_char.data;
        if (cs == ST_TYPE) begin
            {o_header.file_end, o_header.channel_id, o_header.data_type,
             o_header.line_number[23:16]} <= i_char.data;
        end
        if (cs == ST_LINE) o_header.line_number[15:0] <= i_char.data;
        if (cs == ST_LENGTH) o_header.data_length <= i_char.data;
    end

    // at least one payload word, check and end1 lie between the two strobes
    a_hdr_before_done: assert property (
        @(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_hdr_valid |-> (!o_frame_done) [*3]
    );

endmodule

`default_nettype wire

/* verilog/rx_word_packer.sv */
// packs 16-bit payload words into 64-bit DDR words, zero fill at frame end
`timescale 1ns/1ps
`default_nettype none

module rx_word_packer
    import rx_link_pkg::*;
(
    input  wire              i_2711_rx_clk,
    input  wire              i_rst_n,
    input  wire              i_word_valid,
    input  wire [15:0]       i_word,
    input  wire              i_frame_done,
    output logic             o_wr_valid,
    output logic [DDR_W-1:0] o_wr_data
);

    logic [1:0] lane_cnt;

    // a partial group is closed as soon as the word stream pauses
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lane_cnt   <= 2'd0;
            o_wr_valid <= 1'b0;
        end else if (i_word_valid) begin
            lane_cnt   <= lane_cnt + 2'd1;
            o_wr_valid <= (lane_cnt == 2'd3);
        end else begin
            lane_cnt   <= 2'd0;
            o_wr_valid <= (lane_cnt != 2'd0);
        end
    end

    // first word ends up in bits 63..48
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_word_valid) begin
            o_wr_data <= {o_wr_data[DDR_W-17:0], i_word};
        end else begin
            case (lane_cnt)
                2'd1: o_wr_data <= {o_wr_data[15:0], 48'd0};
                2'd2: o_wr_data <= {o_wr_data[31:0], 32'd0};
                2'd3: o_wr_data <= {o_wr_data[47:0], 16'd0};
                default: ;
            endcase
        end
    end

    // last group of the frame is out by the time the parser finishes
    a_group_closed: assert property (
        @(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        i_frame_done |-> (lane_cnt == 2'd0)
    );

    a_wr_spaced: assert property (
        @(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_wr_valid |=> !o_wr_valid
    );

endmodule

`default_nettype wire

/* verilog/rx_dma_cmd_gen.sv */
// DMA write command per frame with 8-byte rounding and running address
`timescale 1ns/1ps
`default_nettype none

module rx_dma_cmd_gen
    import rx_link_pkg::*;
(
    input  wire              i_2711_rx_clk,
    input  wire              i_rst_n,
    input  wire              i_rx_start,
    input  wire [ADDR_W-1:0] i_rx_base_addr,
    input  wire              i_hdr_valid,
    input  wire  rx_header_t i_header,
    input  wire              i_frame_done,
    output logic             o_cmd_valid,
    output dma_cmd_t         o_cmd
);

    logic [ADDR_W-1:0] wr_addr;
    logic [15:0]       byte_cnt;
    logic [15:0]       round_len;

    // DDR is written in whole 8-byte words
    assign round_len = {i_header.data_length[15:3] + 13'(|i_header.data_length[2:0]),
                        3'b000};

    assign o_cmd = '{addr: wr_addr, byte_count: byte_cnt};

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_cmd_valid <= 1'b0;
            byte_cnt    <= '0;
            wr_addr     <= '0;
        end else begin
            o_cmd_valid <= i_hdr_valid;
            if (i_hdr_valid) byte_cnt <= round_len;
            if (i_rx_start) begin
                wr_addr <= i_rx_base_addr;
            end else if (i_frame_done) begin
                wr_addr <= wr_addr + ADDR_W'(byte_cnt);
            end
        end
    end

    a_cmd_rounded: assert property (
        @(posedge i_2711_rx_clk) disable iff (!i_rst_n)
        o_cmd_valid |-> (o_cmd.byte_count[2:0] == 3'd0) &&
            (16'(o_cmd.byte_count - $past(i_header.data_length)) < 16'd8)
    );

endmodule

`default_nettype wire

/* verilog/rx_intr_gen.sv */
// frame counter and interrupt pulse of programmable width
`timescale 1ns/1ps
`default_nettype none

module rx_intr_gen (
    input  wire        i_2711_rx_clk,
    input  wire        i_rst_n,
    input  wire        i_frame_done,
    input  wire [23:0] i_frames_per_intr,
    input  wire [15:0] i_intr_width,
    output logic       o_rx_interrupt
);

    logic [23:0] frame_cnt;
    logic [15:0] width_cnt;
    logic        intr_fire;

    // count including the frame that is finishing now
    assign intr_fire = i_frame_done && (frame_cnt + 24'd1 == i_frames_per_intr);

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frame_cnt <= '0;
        end else if (intr_fire) begin
            frame_cnt <= '0;
        end else if (i_frame_done) begin
            frame_cnt <= frame_cnt + 24'd1;
        end
    end

    // frames during the pulse keep counting above
    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rx_interrupt <= 1'b0;
            width_cnt      <= '0;
        end else if (intr_fire) begin
            o_rx_interrupt <= 1'b1;
            width_cnt      <= '0;
        end else if (o_rx_interrupt) begin
            if (width_cnt == i_intr_width - 16'd1) begin
                o_rx_interrupt <= 1'b0;
                width_cnt      <= '0;
            end else begin
                width_cnt <= width_cnt + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/rx_loss_monitor.sv */
// link-loss and sync-loss detectors, each followed by a holdoff window
`timescale 1ns/1ps
`default_nettype none

module rx_loss_monitor
    import rx_link_pkg::*;
#(
    parameter logic [23:0] LOSS_HOLDOFF = 24'd10000000
)
(
    input  wire           i_2711_rx_clk,
    input  wire           i_rst_n,
    input  wire rx_char_t i_char,
    input  wire           i_in_frame,
    input  wire           i_link_loss_detect_ena,
    input  wire           i_sync_loss_detect_ena,
    output logic          o_link_loss,
    output logic          o_sync_loss
);

    // slot 0 is link loss, slot 1 is sync loss
    logic [1:0]       det_ena;
    logic [1:0]       det_hit;
    logic [1:0]       loss_q;
    logic [1:0]       hold_q;
    logic [1:0][23:0] hold_timer;

    assign det_ena    = {i_sync_loss_detect_ena, i_link_loss_detect_ena};
    assign det_hit[0] = (i_char == CHAR_LINK_DOWN);
    // no K character belongs between the type word and the check word
    assign det_hit[1] = (i_char.rkmsb | i_char.rklsb) & i_in_frame;

    assign o_link_loss = loss_q[0];
    assign o_sync_loss = loss_q[1];

    ////////////////////////////////////////////////////////////////////////////
    // strobe and holdoff, timer counts from the strobe cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            loss_q     <= '0;
            hold_q     <= '0;
            hold_timer <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!det_ena[i]) begin
                    loss_q[i]     <= 1'b0;
                    hold_q[i]     <= 1'b0;
                    hold_timer[i] <= '0;
                end else if (det_hit[i] && !hold_q[i]) begin
                    loss_q[i]     <= 1'b1;
                    hold_q[i]     <= 1'b1;
                    hold_timer[i] <= '0;
                end else begin
                    loss_q[i] <= 1'b0;
                    if (hold_q[i]) begin
                        hold_timer[i] <= hold_timer[i] + 24'd1;
                        // release so a strobe can land LOSS_HOLDOFF after the last
                        if (hold_timer[i] == LOSS_HOLDOFF - 24'd2) hold_q[i] <= 1'b0;
                    end else begin
                        hold_timer[i] <= '0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/tlk2711_rx_link.sv */
// TLK2711 receive link top level: parser, packer, DMA command,
// interrupt and loss monitor
`timescale 1ns/1ps
`default_nettype none

module tlk2711_rx_link
    import rx_link_pkg::*;
#(
    parameter logic [23:0] LOSS_HOLDOFF = 24'd10000000
)
(
    input  wire              i_2711_rx_clk,
    input  wire              i_rst_n,
    input  wire rx_char_t    i_char,
    input  wire              i_rx_start,
    input  wire [ADDR_W-1:0] i_rx_base_addr,
    input  wire [23:0]       i_frames_per_intr,
    input  wire [15:0]       i_intr_width,
    input  wire              i_link_loss_detect_ena,
    input  wire              i_sync_loss_detect_ena,
    output logic             o_wr_valid,
    output logic [DDR_W-1:0] o_wr_data,
    output logic             o_cmd_valid,
    output dma_cmd_t         o_cmd,
    output logic             o_frame_done,
    output rx_header_t       o_header,
    output logic             o_checksum_error,
    output logic             o_rx_interrupt,
    output logic             o_link_loss,
    output logic             o_sync_loss
);

    logic        word_valid;
    logic [15:0] word;
    logic        hdr_valid;
    logic        in_frame;

    rx_frame_parser u_rx_frame_parser (
        .i_2711_rx_clk    (i_2711_rx_clk),
        .i_rst_n          (i_rst_n),
        .i_char           (i_char),
        .o_word_valid     (word_valid),
        .o_word           (word),
        .o_hdr_valid      (hdr_valid),
        .o_header         (o_header),
        .o_frame_done     (o_frame_done),
        .o_checksum_error (o_checksum_error),
        .o_in_frame       (in_frame)
    );

    rx_word_packer u_rx_word_packer (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst_n       (i_rst_n),
        .i_word_valid  (word_valid),
        .i_word        (word),
        .i_frame_done  (o_frame_done),
        .o_wr_valid    (o_wr_valid),
        .o_wr_data     (o_wr_data)
    );

    rx_dma_cmd_gen u_rx_dma_cmd_gen (
        .i_2711_rx_clk  (i_2711_rx_clk),
        .i_rst_n        (i_rst_n),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_hdr_valid    (hdr_valid),
        .i_header       (o_header),
        .i_frame_done   (o_frame_done),
        .o_cmd_valid    (o_cmd_valid),
        .o_cmd          (o_cmd)
    );

    rx_intr_gen u_rx_intr_gen (
        .i_2711_rx_clk     (i_2711_rx_clk),
        .i_rst_n           (i_rst_n),
        .i_frame_done      (o_frame_done),
        .i_frames_per_intr (i_frames_per_intr),
        .i_intr_width      (i_intr_width),
        .o_rx_interrupt    (o_rx_interrupt)
    );

    rx_loss_monitor #(
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_rx_loss_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst_n                (i_rst_n),
        .i_char                 (i_char),
        .i_in_frame             (in_frame),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

endmodule

`default_nettype wire

/* verification/tb_tlk2711_rx_link.sv */
// testbench for the TLK2711 receive link with random frames, reference model,
// strobe comparison, interrupt and loss detector checks
`timescale 1ns/1ps
`default_nettype none

module tb_tlk2711_rx_link
    import rx_link_pkg::*;
();

    localparam logic [ADDR_W-1:0] BASE_ADDR   = 32'h1000_0100;
    localparam int                TIMEOUT_CYC = 2000;

    logic              clk;
    logic              rst_n;
    rx_char_t          rx_char;
    logic              rx_start;
    logic [ADDR_W-1:0] rx_base_addr;
    logic [23:0]       frames_per_intr;
    logic [15:0]       intr_width;
    logic              link_ena;
    logic              sync_ena;
    logic              wr_valid;
    logic [DDR_W-1:0]  wr_data;
    logic              cmd_valid;
    dma_cmd_t          cmd;
    logic              frame_done;
    rx_header_t        header;
    logic              csum_err;
    logic              rx_intr;
    logic              link_loss;
    logic              sync_loss;

    integer            seed;
    logic [15:0]       payload [20];
    logic [ADDR_W-1:0] exp_addr;

    // expected strobes as the frame generator queues them
    rx_header_t        exp_hdr_q[$];
    bit                exp_err_q[$];
    int                exp_nw_q[$];
    logic [DDR_W-1:0]  exp_word_q[$];
    dma_cmd_t          exp_cmd_q[$];

    int                words_seen;
    int                intr_phase;
    int                intr_left;
    int                link_cnt;
    int                sync_cnt;
    int                cyc;
    int                link_cyc_q[$];

    tlk2711_rx_link #(
        .LOSS_HOLDOFF (24'd64)
    ) u_tlk2711_rx_link (
        .i_2711_rx_clk          (clk),
        .i_rst_n                (rst_n),
        .i_char                 (rx_char),
        .i_rx_start             (rx_start),
        .i_rx_base_addr         (rx_base_addr),
        .i_frames_per_intr      (frames_per_intr),
        .i_intr_width           (intr_width),
        .i_link_loss_detect_ena (link_ena),
        .i_sync_loss_detect_ena (sync_ena),
        .o_wr_valid             (wr_valid),
        .o_wr_data              (wr_data),
        .o_cmd_valid            (cmd_valid),
        .o_cmd                  (cmd),
        .o_frame_done           (frame_done),
        .o_header               (header),
        .o_checksum_error       (csum_err),
        .o_rx_interrupt         (rx_intr),
        .o_link_loss            (link_loss),
        .o_sync_loss            (sync_loss)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] type_word(input rx_header_t h);
        return {h.file_end, h.channel_id, h.data_type, h.line_number[23:16]};
    endfunction

    // wrapping sum of type, line, length and payload
    function automatic logic [15:0] frame_checksum(input rx_header_t h, input int n);
        logic [15:0] sum;
        int          i;
        sum = type_word(h) + h.line_number[15:0] + h.data_length;
        for (i = 0; i < n; i++) begin
            sum = sum + payload[i];
        end
        return sum;
    endfunction

    function automatic logic [15:0] round_up8(input logic [15:0] len);
        logic [16:0] v;
        v = {1'b0, len} + 17'd7;
        return {v[15:3], 3'b000};
    endfunction

    // group g of four payload words with the first word high and zeros past the end
    function automatic logic [DDR_W-1:0] packed_word(input int n, input int g);
        logic [DDR_W-1:0] w;
        int               lane;
        int               idx;
        w = '0;
        for (lane = 0; lane < 4; lane++) begin
            idx = 4 * g + lane;
            w   = {w[DDR_W-17:0], (idx < n) ? payload[idx] : 16'h0000};
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic drive_char(input rx_char_t c);
        @(negedge clk);
        rx_char = c;
    endtask

    task automatic drive_data(input logic [15:0] d);
        drive_char('{rkmsb: 1'b0, rklsb: 1'b0, data: d});
    endtask

    // k_pos is the payload word sent with a K flag or -1 for none
    task automatic send_frame(input bit corrupt, input int k_pos);
        rx_header_t  h;
        logic [31:0] r;
        logic [15:0] check;
        logic [15:0] bc;
        rx_char_t    c;
        int          n;
        int          i;
        r = $random(seed);
        h.file_end    = r[1:0];
        h.channel_id  = r[3:2];
        h.data_type   = r[7:4];
        h.line_number = r[31:8];
        r = $random(seed);
        h.data_length = 16'd2 + (r[15:0] % 16'd39);
        n = (int'(h.data_length) + 1) / 2;
        for (i = 0; i < n; i++) begin
            r = $random(seed);
            payload[i] = r[15:0];
        end
        check = frame_checksum(h, n);
        if (corrupt) check = ~check;
        bc = round_up8(h.data_length);

        exp_hdr_q.push_back(h);
        exp_err_q.push_back(corrupt);
        exp_nw_q.push_back((n + 3) / 4);
        for (i = 0; i < (n + 3) / 4; i++) begin
            exp_word_q.push_back(packed_word(n, i));
        end
        exp_cmd_q.push_back('{addr: exp_addr, byte_count: bc});
        exp_addr = exp_addr + ADDR_W'(bc);

        drive_char(CHAR_SYNC);
        drive_char(CHAR_SOF);
        drive_data(FRAME_HEAD_FLAG[31:16]);
        drive_data(FRAME_HEAD_FLAG[15:0]);
        drive_data(type_word(h));
        drive_data(h.line_number[15:0]);
        drive_data(h.data_length);
        for (i = 0; i < n; i++) begin
            c = '{rkmsb: 1'b0, rklsb: (i == k_pos), data: payload[i]};
            drive_char(c);
        end
        drive_data(check);
        // two end characters and idle after them
        repeat (5) drive_data(16'h0000);
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_hdr_q.size() != 0 || exp_word_q.size() != 0 || exp_cmd_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT_CYC) fail_run("timeout: the DUT did not finish the expected frames");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // comparison
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            cyc++;
            // a padding word may share its cycle with frame done
            if (wr_valid) begin
                assert (exp_word_q.size() > 0) else fail_run("unexpected write word from the DUT");
                assert (wr_data === exp_word_q[0]) else fail_run($sformatf(
                    "Error at %0t: wr_data %h, expected %h", $time, wr_data, exp_word_q[0]));
                void'(exp_word_q.pop_front());
                words_seen++;
            end
            if (cmd_valid) begin
                assert (exp_cmd_q.size() > 0) else fail_run("unexpected DMA command from the DUT");
                assert (cmd === exp_cmd_q[0]) else fail_run($sformatf(
                    "Error at %0t: command %h, expected %h", $time, cmd, exp_cmd_q[0]));
                void'(exp_cmd_q.pop_front());
            end
            if (frame_done) begin
                assert (exp_hdr_q.size() > 0) else fail_run("unexpected frame done from the DUT");
                assert (header === exp_hdr_q[0]) else fail_run($sformatf(
                    "Error at %0t: header %h, expected %h", $time, header, exp_hdr_q[0]));
                assert (csum_err === exp_err_q[0]) else fail_run($sformatf(
                    "Error at %0t: checksum error %b, expected %b", $time, csum_err,
                    exp_err_q[0]));
                assert (words_seen == exp_nw_q[0]) else fail_run($sformatf(
                    "Error at %0t: %0d words in frame, expected %0d", $time, words_seen,
                    exp_nw_q[0]));
                void'(exp_hdr_q.pop_front());
                void'(exp_err_q.pop_front());
                void'(exp_nw_q.pop_front());
                words_seen = 0;
            end

            // interrupt level follows the frame count
            assert (rx_intr === (intr_left > 0)) else fail_run($sformatf(
                "Error at %0t: interrupt %b, expected %b", $time, rx_intr, intr_left > 0));
            if (intr_left > 0) intr_left--;
            if (frame_done) begin
                intr_phase++;
                if (intr_phase == int'(frames_per_intr)) begin
                    intr_phase = 0;
                    intr_left  = int'(intr_width);
                end
            end

            if (link_loss) begin
                link_cnt++;
                link_cyc_q.push_back(cyc);
            end
            if (sync_loss) sync_cnt++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          i;
        seed            = 35;
        rst_n           = 1'b0;
        rx_char         = '0;
        rx_start        = 1'b0;
        rx_base_addr    = '0;
        frames_per_intr = 24'd3;
        intr_width      = 16'd5;
        link_ena        = 1'b1;
        sync_ena        = 1'b1;
        exp_addr        = BASE_ADDR;
        words_seen      = 0;
        intr_phase      = 0;
        intr_left       = 0;
        link_cnt        = 0;
        sync_cnt        = 0;
        cyc             = 0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        rx_base_addr = BASE_ADDR;
        rx_start     = 1'b1;
        @(negedge clk);
        rx_start = 1'b0;

        // random frames of which some carry a bad checksum
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            send_frame(r[0], -1);
        end
        wait_drained();
        assert (link_cnt == 0 && sync_cnt == 0) else fail_run("loss strobe during clean frames");

        // K flag on the first payload word
        send_frame(1'b0, 0);
        wait_drained();
        assert (sync_cnt == 1) else fail_run($sformatf(
            "Error at %0t: %0d sync loss strobes, expected 1", $time, sync_cnt));
        // sync holdoff window runs out before detection goes off
        repeat (70) drive_data(16'h0000);
        sync_ena = 1'b0;
        send_frame(1'b0, 0);
        wait_drained();
        assert (sync_cnt == 1) else fail_run($sformatf(
            "Error at %0t: %0d sync loss strobes with detection off, expected 1", $time,
            sync_cnt));

        // link-down burst longer than one holdoff window
        repeat (70) drive_char(CHAR_LINK_DOWN);
        repeat (4) drive_data(16'h0000);
        assert (link_cnt == 2) else fail_run($sformatf(
            "Error at %0t: %0d link loss strobes, expected 2", $time, link_cnt));
        assert (link_cyc_q[1] - link_cyc_q[0] == 64) else fail_run($sformatf(
            "Error at %0t: link loss strobes %0d cycles apart, expected 64", $time,
            link_cyc_q[1] - link_cyc_q[0]));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tlk2711_rx_link.f */
verilog/rx_link_pkg.sv
verilog/rx_frame_parser.sv
verilog/rx_word_packer.sv
verilog/rx_dma_cmd_gen.sv
verilog/rx_intr_gen.sv
verilog/rx_loss_monitor.sv
verilog/tlk2711_rx_link.sv
verification/tb_tlk2711_rx_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_tlk2711_rx_link
FILELIST  := tlk2711_rx_link.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
